// ==== hdl/monitor_pkg.sv ====
package monitor_pkg;

	// Serial frame
	localparam int DATA_BITS = 8;
	localparam int FRAME_BITS = 10;   // Start, data, stop

	// Register port
	localparam int ADDR_WIDTH = 6;
	localparam int WORD_WIDTH = 16;

	// Buffers and line layout
	localparam int LINE_DEPTH = 32;
	localparam int REPLY_DEPTH = 17;  // Space plus one digit per word bit
	localparam int ADDR_FIRST_CHAR = 2;
	localparam int DATA_FIRST_CHAR = 9;

	typedef logic [DATA_BITS-1:0] char_t;
	typedef logic [ADDR_WIDTH-1:0] reg_addr_t;
	typedef logic [WORD_WIDTH-1:0] reg_word_t;
	typedef logic [$clog2(FRAME_BITS)-1:0] frame_pos_t;
	typedef logic [$clog2(LINE_DEPTH)-1:0] line_index_t;
	typedef logic [$clog2(REPLY_DEPTH + 1)-1:0] reply_index_t;

	// ASCII codes
	localparam char_t CHAR_CR = 8'd13;
	localparam char_t CHAR_SPACE = 8'd32;
	localparam char_t CHAR_ZERO = 8'd48;

	// Command letters, first character of a line
	localparam char_t CMD_STOP = "S";
	localparam char_t CMD_CONTINUE = "C";
	localparam char_t CMD_STEP = "+";
	localparam char_t CMD_READ_REG = "G";
	localparam char_t CMD_WRITE_REG = "W";

endpackage

// ==== hdl/frame_counter.sv ====
`timescale 1ns/10ps

module frame_counter (
	input  logic i_uart_clock,
	input  logic i_reset,
	input  logic i_start,
	output logic o_active,
	output monitor_pkg::frame_pos_t o_pos,
	output logic o_last
);

	// Position 0 is the cycle in which i_start is seen
	always_ff @(posedge i_uart_clock or posedge i_reset) begin
		if (i_reset) begin
			o_active <= 1'b0;
			o_pos <= '0;
		end else if (o_last) begin
			o_active <= 1'b0;
			o_pos <= '0;
		end else if (o_active) begin
			o_pos <= o_pos + 1'b1;
		end else if (i_start) begin
			o_active <= 1'b1;
			o_pos <= monitor_pkg::frame_pos_t'(1);
		end
	end

	assign o_last = o_active && (o_pos == monitor_pkg::frame_pos_t'(monitor_pkg::FRAME_BITS - 1));

endmodule

// ==== hdl/uart_rx.sv ====
`timescale 1ns/10ps

module uart_rx (
	input  logic i_uart_clock,
	input  logic i_reset,
	input  logic i_uart_rx,
	output monitor_pkg::char_t o_char,
	output logic o_char_valid
);

	logic rx_active;
	logic rx_last;
	logic start_bit;
	monitor_pkg::frame_pos_t rx_pos;
	monitor_pkg::char_t rx_shift;

	assign start_bit = !rx_active && !i_uart_rx;  // Falling line while idle

	frame_counter frame_counter_i (
		.i_uart_clock(i_uart_clock),
		.i_reset(i_reset),
		.i_start(start_bit),
		.o_active(rx_active),
		.o_pos(rx_pos),
		.o_last(rx_last)
	);

	// Data bits sit at positions 1 to 8, LSB first
	always_ff @(posedge i_uart_clock) begin
		if (rx_active && (rx_pos <= monitor_pkg::frame_pos_t'(monitor_pkg::DATA_BITS))) begin
			rx_shift <= {i_uart_rx, rx_shift[monitor_pkg::DATA_BITS-1:1]};
		end
	end

	assign o_char = rx_shift;
	assign o_char_valid = rx_last;  // Stop bit cycle, stop level not checked

endmodule

// ==== hdl/uart_tx.sv ====
`timescale 1ns/10ps

module uart_tx (
	input  logic i_uart_clock,
	input  logic i_reset,
	input  logic i_tx_req,
	input  monitor_pkg::char_t i_tx_char,
	output logic o_tx_ack,
	output logic o_uart_tx
);

	logic pending;
	logic accept;
	logic tx_active;
	logic tx_last;
	logic [2:0] bit_sel;
	monitor_pkg::frame_pos_t tx_pos;
	monitor_pkg::char_t tx_data;

	assign accept = i_tx_req && !o_tx_ack && !pending && !tx_active;

	always_ff @(posedge i_uart_clock or posedge i_reset) begin
		if (i_reset) begin
			pending <= 1'b0;
			o_tx_ack <= 1'b0;
		end else begin
			pending <= accept;  // One cycle of start bit
			if (tx_last)
				o_tx_ack <= 1'b1;
			else if (!i_tx_req)
				o_tx_ack <= 1'b0;  // Req has dropped
		end
	end

	always_ff @(posedge i_uart_clock) begin
		if (accept)
			tx_data <= i_tx_char;
	end

	frame_counter frame_counter_i (
		.i_uart_clock(i_uart_clock),
		.i_reset(i_reset),
		.i_start(pending),
		.o_active(tx_active),
		.o_pos(tx_pos),
		.o_last(tx_last)
	);

	assign bit_sel = 3'(tx_pos - 1'b1);

	always_comb begin
		if (pending)
			o_uart_tx = 1'b0;
		else if (tx_active && !tx_last)
			o_uart_tx = tx_data[bit_sel];
		else
			o_uart_tx = 1'b1;  // Stop bit and idle line
	end

endmodule

// ==== hdl/line_buffer.sv ====
`timescale 1ns/10ps

module line_buffer (
	input  logic i_uart_clock,
	input  logic i_reset,
	input  monitor_pkg::char_t i_char,
	input  logic i_char_valid,
	output monitor_pkg::char_t o_command,
	output monitor_pkg::reg_addr_t o_field_addr,
	output monitor_pkg::reg_word_t o_field_data,
	output logic o_line_done
);

	monitor_pkg::char_t line_mem [monitor_pkg::LINE_DEPTH];
	monitor_pkg::line_index_t wr_index;
	logic is_cr;

	assign is_cr = (i_char == monitor_pkg::CHAR_CR);

	always_ff @(posedge i_uart_clock or posedge i_reset) begin
		if (i_reset) begin
			wr_index <= '0;
			o_line_done <= 1'b0;
		end else begin
			o_line_done <= i_char_valid && is_cr;
			if (i_char_valid) begin
				if (is_cr)
					wr_index <= '0;  // Next line starts over
				else if (wr_index == monitor_pkg::line_index_t'(monitor_pkg::LINE_DEPTH - 1))
					wr_index <= '0;
				else
					wr_index <= wr_index + 1'b1;
			end
		end
	end

	always_ff @(posedge i_uart_clock) begin
		if (i_char_valid)
			line_mem[wr_index] <= i_char;
	end

	// Digit value is the low bit of its character, MSB first on the line
	always_comb begin
		for (int k = 0; k < monitor_pkg::ADDR_WIDTH; k++) begin
			o_field_addr[monitor_pkg::ADDR_WIDTH-1-k] = line_mem[monitor_pkg::ADDR_FIRST_CHAR + k][0];
		end
		for (int k = 0; k < monitor_pkg::WORD_WIDTH; k++) begin
			o_field_data[monitor_pkg::WORD_WIDTH-1-k] = line_mem[monitor_pkg::DATA_FIRST_CHAR + k][0];
		end
	end

	assign o_command = line_mem[0];

endmodule

// ==== hdl/reply_buffer.sv ====
`timescale 1ns/10ps

module reply_buffer (
	input  logic i_uart_clock,
	input  logic i_reset,
	input  monitor_pkg::char_t i_echo_char,
	input  logic i_load_echo,
	input  logic i_load_space,
	input  logic i_load_word,
	input  monitor_pkg::reg_word_t i_reply_word,
	output logic o_busy,
	output logic o_tx_req,
	output monitor_pkg::char_t o_tx_char,
	input  logic i_tx_ack
);

	monitor_pkg::char_t reply_mem [monitor_pkg::REPLY_DEPTH];
	monitor_pkg::reply_index_t rd_index;
	monitor_pkg::reply_index_t last_index;
	logic load_any;

	assign load_any = (i_load_echo || i_load_space || i_load_word) && !o_busy;  // Ignored while busy

	always_ff @(posedge i_uart_clock or posedge i_reset) begin
		if (i_reset) begin
			o_busy <= 1'b0;
			o_tx_req <= 1'b0;
			rd_index <= '0;
			last_index <= '0;
		end else if (load_any) begin
			o_busy <= 1'b1;
			rd_index <= '0;
			last_index <= i_load_word ? monitor_pkg::reply_index_t'(monitor_pkg::REPLY_DEPTH - 1) : '0;
		end else if (o_busy) begin
			if (o_tx_req && i_tx_ack) begin
				o_tx_req <= 1'b0;
				if (rd_index == last_index) begin
					o_busy <= 1'b0;
					rd_index <= '0;
				end else begin
					rd_index <= rd_index + 1'b1;
				end
			end else if (!o_tx_req && !i_tx_ack) begin
				o_tx_req <= 1'b1;  // Previous ack fully released
			end
		end
	end

	// Digits are always formatted, only a word load reads past slot 0
	always_ff @(posedge i_uart_clock) begin
		if (load_any) begin
			reply_mem[0] <= i_load_echo ? i_echo_char : monitor_pkg::CHAR_SPACE;
			for (int k = 0; k < monitor_pkg::WORD_WIDTH; k++) begin
				reply_mem[k + 1] <= monitor_pkg::CHAR_ZERO +
					monitor_pkg::char_t'(i_reply_word[monitor_pkg::WORD_WIDTH-1-k]);
			end
		end
	end

	assign o_tx_char = reply_mem[rd_index];

endmodule

// ==== hdl/monitor_fsm.sv ====
`timescale 1ns/10ps

module monitor_fsm (
	input  logic i_uart_clock,
	input  logic i_reset,
	input  logic i_char_valid,
	input  monitor_pkg::char_t i_char,
	input  logic i_line_done,
	input  monitor_pkg::char_t i_command,
	input  monitor_pkg::reg_addr_t i_field_addr,
	input  monitor_pkg::reg_word_t i_field_data,
	input  logic i_reply_busy,
	output logic o_load_echo,
	output logic o_load_space,
	output logic o_load_word,
	output monitor_pkg::reg_word_t o_reply_word,
	output logic o_stop,
	output logic o_continue,
	output logic o_step,
	output monitor_pkg::reg_addr_t o_step_count,
	output logic o_reg_req,
	output logic o_reg_we,
	output monitor_pkg::reg_addr_t o_reg_addr,
	output monitor_pkg::reg_word_t o_reg_wdata,
	input  logic i_reg_ack,
	input  monitor_pkg::reg_word_t i_reg_rdata
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_DISPATCH,
		ST_REQUEST,
		ST_RELEASE,
		ST_REPLY
	} state_t;

	state_t state;
	logic is_reg_cmd;
	logic read_cmd;
	logic line_start;

	assign is_reg_cmd = (i_command == monitor_pkg::CMD_READ_REG) ||
		(i_command == monitor_pkg::CMD_WRITE_REG);
	assign line_start = (state == ST_IDLE) && i_line_done;

	always_ff @(posedge i_uart_clock or posedge i_reset) begin
		if (i_reset) begin
			state <= ST_IDLE;
			o_load_echo <= 1'b0;
			o_stop <= 1'b0;
			o_continue <= 1'b0;
			o_step <= 1'b0;
			o_reg_req <= 1'b0;
		end else begin
			o_load_echo <= i_char_valid && (i_char != monitor_pkg::CHAR_CR) && !i_reply_busy;
			o_stop <= line_start && (i_command == monitor_pkg::CMD_STOP);
			o_continue <= line_start && (i_command == monitor_pkg::CMD_CONTINUE);
			o_step <= line_start && (i_command == monitor_pkg::CMD_STEP);
			case (state)
				ST_IDLE: begin
					if (i_line_done) begin
						state <= ST_DISPATCH;
						o_reg_req <= is_reg_cmd;
					end
				end
				ST_DISPATCH: state <= o_reg_req ? ST_REQUEST : ST_REPLY;  // Pulse cycle
				ST_REQUEST: begin
					if (i_reg_ack) begin
						o_reg_req <= 1'b0;
						state <= ST_RELEASE;
					end
				end
				ST_RELEASE: if (!i_reg_ack) state <= ST_REPLY;
				ST_REPLY: if (!i_reply_busy) state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Request fields held from dispatch until the handshake ends
	always_ff @(posedge i_uart_clock) begin
		if (line_start) begin
			read_cmd <= (i_command == monitor_pkg::CMD_READ_REG);
			if (i_command == monitor_pkg::CMD_STEP)
				o_step_count <= i_field_addr;
			if (is_reg_cmd) begin
				o_reg_we <= (i_command == monitor_pkg::CMD_WRITE_REG);
				o_reg_addr <= i_field_addr;
				o_reg_wdata <= i_field_data;
			end
		end
		if ((state == ST_REQUEST) && i_reg_ack)
			o_reply_word <= i_reg_rdata;
	end

	assign o_load_space = (state == ST_REPLY) && !i_reply_busy && !read_cmd;
	assign o_load_word = (state == ST_REPLY) && !i_reply_busy && read_cmd;

endmodule

// ==== hdl/debug_monitor_top.sv ====
`timescale 1ns/10ps

module debug_monitor_top (
	input  logic i_uart_clock,
	input  logic i_reset,
	input  logic i_uart_rx,
	output logic o_uart_tx,
	output logic o_stop,
	output logic o_continue,
	output logic o_step,
	output monitor_pkg::reg_addr_t o_step_count,
	output logic o_reg_req,
	output logic o_reg_we,
	output monitor_pkg::reg_addr_t o_reg_addr,
	output monitor_pkg::reg_word_t o_reg_wdata,
	input  logic i_reg_ack,
	input  monitor_pkg::reg_word_t i_reg_rdata
);

	monitor_pkg::char_t rx_char;
	monitor_pkg::char_t command;
	monitor_pkg::char_t tx_char;
	monitor_pkg::reg_addr_t field_addr;
	monitor_pkg::reg_word_t field_data;
	monitor_pkg::reg_word_t reply_word;
	logic rx_char_valid;
	logic line_done;
	logic load_echo;
	logic load_space;
	logic load_word;
	logic reply_busy;
	logic tx_req;
	logic tx_ack;

	uart_rx uart_rx_i (
		.i_uart_clock(i_uart_clock),
		.i_reset(i_reset),
		.i_uart_rx(i_uart_rx),
		.o_char(rx_char),
		.o_char_valid(rx_char_valid)
	);

	line_buffer line_buffer_i (
		.i_uart_clock(i_uart_clock),
		.i_reset(i_reset),
		.i_char(rx_char),
		.i_char_valid(rx_char_valid),
		.o_command(command),
		.o_field_addr(field_addr),
		.o_field_data(field_data),
		.o_line_done(line_done)
	);

	monitor_fsm monitor_fsm_i (
		.i_uart_clock(i_uart_clock),
		.i_reset(i_reset),
		.i_char_valid(rx_char_valid),
		.i_char(rx_char),
		.i_line_done(line_done),
		.i_command(command),
		.i_field_addr(field_addr),
		.i_field_data(field_data),
		.i_reply_busy(reply_busy),
		.o_load_echo(load_echo),
		.o_load_space(load_space),
		.o_load_word(load_word),
		.o_reply_word(reply_word),
		.o_stop(o_stop),
		.o_continue(o_continue),
		.o_step(o_step),
		.o_step_count(o_step_count),
		.o_reg_req(o_reg_req),
		.o_reg_we(o_reg_we),
		.o_reg_addr(o_reg_addr),
		.o_reg_wdata(o_reg_wdata),
		.i_reg_ack(i_reg_ack),
		.i_reg_rdata(i_reg_rdata)
	);

	// Receiver still holds the character when the echo is loaded
	reply_buffer reply_buffer_i (
		.i_uart_clock(i_uart_clock),
		.i_reset(i_reset),
		.i_echo_char(rx_char),
		.i_load_echo(load_echo),
		.i_load_space(load_space),
		.i_load_word(load_word),
		.i_reply_word(reply_word),
		.o_busy(reply_busy),
		.o_tx_req(tx_req),
		.o_tx_char(tx_char),
		.i_tx_ack(tx_ack)
	);

	uart_tx uart_tx_i (
		.i_uart_clock(i_uart_clock),
		.i_reset(i_reset),
		.i_tx_req(tx_req),
		.i_tx_char(tx_char),
		.o_tx_ack(tx_ack),
		.o_uart_tx(o_uart_tx)
	);

endmodule

// ==== sim/debug_monitor_checker.sv ====
`timescale 1ns/10ps

module debug_monitor_checker (
	input  logic i_uart_clock,
	input  logic i_reset,
	input  logic o_uart_tx,
	input  logic o_stop,
	input  logic o_continue,
	input  logic o_step,
	input  logic o_reg_req,
	input  logic o_reg_we,
	input  monitor_pkg::reg_addr_t o_reg_addr,
	input  monitor_pkg::reg_word_t o_reg_wdata,
	input  logic i_reg_ack
);

	int fail_count = 0;  // Failed assertions so far

	// Request held until the environment answers
	req_held: assert property (@(posedge i_uart_clock) disable iff (i_reset)
		o_reg_req && !i_reg_ack |=> o_reg_req)
		else begin
			fail_count++;
			$error("o_reg_req dropped before i_reg_ack rose");
		end

	fields_stable: assert property (@(posedge i_uart_clock) disable iff (i_reset)
		o_reg_req && $past(o_reg_req) |-> $stable({o_reg_we, o_reg_addr, o_reg_wdata}))
		else begin
			fail_count++;
			$error("Register request fields changed while o_reg_req was high");
		end

	one_pulse: assert property (@(posedge i_uart_clock) disable iff (i_reset)
		$onehot0({o_stop, o_continue, o_step}))
		else begin
			fail_count++;
			$error("More than one control pulse high");
		end

	idle_in_reset: assert property (@(posedge i_uart_clock)
		i_reset |-> o_uart_tx)  // Line idles high
		else begin
			fail_count++;
			$error("o_uart_tx low during reset");
		end

endmodule

bind debug_monitor_top debug_monitor_checker checker_i (
	.i_uart_clock(i_uart_clock),
	.i_reset(i_reset),
	.o_uart_tx(o_uart_tx),
	.o_stop(o_stop),
	.o_continue(o_continue),
	.o_step(o_step),
	.o_reg_req(o_reg_req),
	.o_reg_we(o_reg_we),
	.o_reg_addr(o_reg_addr),
	.o_reg_wdata(o_reg_wdata),
	.i_reg_ack(i_reg_ack)
);

// ==== sim/tb_debug_monitor.sv ====
`timescale 1ns/10ps

module tb_debug_monitor;

	localparam int CLOCK_PERIOD = 40;
	localparam int ROWS = 9;
	localparam int PULSE_NONE = 0;
	localparam int PULSE_STOP = 1;
	localparam int PULSE_CONTINUE = 2;
	localparam int PULSE_STEP = 3;
	localparam int ACCESS_NONE = 0;
	localparam int ACCESS_WRITE = 1;
	localparam int ACCESS_READ = 2;

	logic uart_clock = 1'b0;
	logic reset;
	logic uart_rx;
	logic uart_tx;
	logic stop;
	logic cont;
	logic step;
	monitor_pkg::reg_addr_t step_count;
	logic reg_req;
	logic reg_we;
	monitor_pkg::reg_addr_t reg_addr;
	monitor_pkg::reg_word_t reg_wdata;
	logic reg_ack;
	monitor_pkg::reg_word_t reg_rdata;

	// Stimulus and expected values, one row per command line
	string row_line [ROWS];
	int row_pulse [ROWS];
	int row_step [ROWS];
	int row_access [ROWS];
	int row_addr [ROWS];
	int row_data [ROWS];
	string row_reply [ROWS];
	int row_count = 0;

	monitor_pkg::reg_word_t reg_model [64];
	integer seed = 32'h052e2468;
	int timeout_cycles = 0;
	int error_count = 0;
	logic [7:0] tx_chars [$];  // Characters decoded from o_uart_tx
	int stop_count = 0;
	int continue_count = 0;
	int step_pulse_count = 0;
	int last_step_count = 0;
	int access_count = 0;
	int last_we = 0;
	int last_addr = 0;
	int last_data = 0;

	always #(CLOCK_PERIOD / 2) uart_clock = ~uart_clock;

	debug_monitor_top dut_i (
		.i_uart_clock(uart_clock),
		.i_reset(reset),
		.i_uart_rx(uart_rx),
		.o_uart_tx(uart_tx),
		.o_stop(stop),
		.o_continue(cont),
		.o_step(step),
		.o_step_count(step_count),
		.o_reg_req(reg_req),
		.o_reg_we(reg_we),
		.o_reg_addr(reg_addr),
		.o_reg_wdata(reg_wdata),
		.i_reg_ack(reg_ack),
		.i_reg_rdata(reg_rdata)
	);

	// Power-on contents, unique per address
	function automatic monitor_pkg::reg_word_t fill_word(input logic [5:0] addr);
		return {addr, ~addr, addr[3:0]};
	endfunction

	function automatic string word_digits(input logic [15:0] word);
		string s;
		s = "";
		for (int k = 15; k >= 0; k--) begin
			if (word[k])
				s = {s, "1"};
			else
				s = {s, "0"};
		end
		return s;
	endfunction

	task automatic report_failure(input string what);
		error_count++;
		$display("%s", what);
		$display(">>> FAIL");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
			report_failure($sformatf("CHECK FAILED %s: expected 0x%0h, got 0x%0h",
				name, expected, got));
	endtask

	task automatic add_row(input string line, input int pulse, input int count,
		input int access, input int addr, input int data);
		row_line[row_count] = line;
		row_pulse[row_count] = pulse;
		row_step[row_count] = count;
		row_access[row_count] = access;
		row_addr[row_count] = addr;
		row_data[row_count] = data;
		if (access == ACCESS_READ)
			row_reply[row_count] = {" ", word_digits(data[15:0])};  // Space plus MSB-first digits
		else
			row_reply[row_count] = " ";
		row_count++;
	endtask

	task automatic build_table();
		add_row("S", PULSE_STOP, 0, ACCESS_NONE, 0, 0);
		add_row("C", PULSE_CONTINUE, 0, ACCESS_NONE, 0, 0);
		add_row("+ 000101", PULSE_STEP, 5, ACCESS_NONE, 0, 0);
		add_row("W 001010 1100101000110101", PULSE_NONE, 0, ACCESS_WRITE, 10, 'hca35);
		add_row("G 001010", PULSE_NONE, 0, ACCESS_READ, 10, 'hca35);
		add_row("G 100111", PULSE_NONE, 0, ACCESS_READ, 39, fill_word(6'd39));
		add_row("W 111111 0000000011111111", PULSE_NONE, 0, ACCESS_WRITE, 63, 'h00ff);
		add_row("G 111111", PULSE_NONE, 0, ACCESS_READ, 63, 'h00ff);
		add_row("X 000001", PULSE_NONE, 0, ACCESS_NONE, 0, 0);  // Unknown command
	endtask

	// One frame, start bit, LSB first, stop bit
	task automatic send_char(input logic [7:0] ch);
		@(posedge uart_clock);
		uart_rx <= 1'b0;
		for (int b = 0; b < 8; b++) begin
			@(posedge uart_clock);
			uart_rx <= ch[b];
		end
		@(posedge uart_clock);
		uart_rx <= 1'b1;
	endtask

	task automatic wait_tx_chars(input int n);
		while (tx_chars.size() < n)
			@(negedge uart_clock);
	endtask

	always begin : serial_monitor
		logic [7:0] ch;
		@(negedge uart_clock);
		if (!reset && !uart_tx) begin
			for (int b = 0; b < 8; b++) begin
				@(negedge uart_clock);
				ch[b] = uart_tx;
			end
			@(negedge uart_clock);
			if (!uart_tx)
				report_failure("Stop bit on the serial output was low");
			tx_chars.push_back(ch);
		end
	end

	always begin : register_model
		int delay;
		@(negedge uart_clock);
		if (reg_req && !reg_ack) begin
			delay = 1 + ({$random(seed)} % 4);
			access_count++;
			last_we = reg_we;
			last_addr = reg_addr;
			last_data = reg_wdata;
			repeat (delay) @(posedge uart_clock);
			if (reg_we)
				reg_model[reg_addr] = reg_wdata;
			else
				reg_rdata <= reg_model[reg_addr];
			reg_ack <= 1'b1;
			while (reg_req)
				@(negedge uart_clock);
			@(posedge uart_clock);
			reg_ack <= 1'b0;  // Closes the four-phase cycle
		end
	end

	always @(negedge uart_clock) begin
		if (stop)
			stop_count++;
		if (cont)
			continue_count++;
		if (step) begin
			step_pulse_count++;
			last_step_count = step_count;
		end
	end

	// Bound assertions count their failures
	always @(negedge uart_clock) begin
		if (dut_i.checker_i.fail_count != 0)
			report_failure("A bound assertion on the DUT ports failed");
	end

	initial begin : watchdog
		wait (timeout_cycles > 0);
		repeat (timeout_cycles) @(posedge uart_clock);
		report_failure("Timeout: the command table did not complete in the cycle budget");
	end

	initial begin : main_sequence
		int stops_before;
		int continues_before;
		int steps_before;
		int access_before;
		int total_chars;
		string line;
		string reply;
		reset = 1'b1;
		uart_rx = 1'b1;
		reg_ack = 1'b0;
		reg_rdata = '0;
		for (int a = 0; a < 64; a++)
			reg_model[a] = fill_word(a[5:0]);
		build_table();
		total_chars = 0;
		for (int r = 0; r < row_count; r++)
			total_chars += 2 * row_line[r].len() + 1 + row_reply[r].len();
		timeout_cycles = total_chars * 30 + 20;
		repeat (2) @(posedge uart_clock);
		reset <= 1'b0;
		for (int r = 0; r < row_count; r++) begin
			stops_before = stop_count;
			continues_before = continue_count;
			steps_before = step_pulse_count;
			access_before = access_count;
			line = row_line[r];
			for (int i = 0; i < line.len(); i++) begin
				send_char(line[i]);
				wait_tx_chars(1);
				check_value("o_uart_tx echo", tx_chars.pop_front(), line[i]);
			end
			send_char(monitor_pkg::CHAR_CR);
			reply = row_reply[r];
			wait_tx_chars(reply.len());
			for (int i = 0; i < reply.len(); i++)
				check_value("o_uart_tx reply", tx_chars.pop_front(), reply[i]);
			check_value("o_stop pulses", stop_count - stops_before, row_pulse[r] == PULSE_STOP);
			check_value("o_continue pulses", continue_count - continues_before,
				row_pulse[r] == PULSE_CONTINUE);
			check_value("o_step pulses", step_pulse_count - steps_before,
				row_pulse[r] == PULSE_STEP);
			if (row_pulse[r] == PULSE_STEP)
				check_value("o_step_count", last_step_count, row_step[r]);
			check_value("o_reg_req handshakes", access_count - access_before,
				row_access[r] != ACCESS_NONE);
			if (row_access[r] != ACCESS_NONE) begin
				check_value("o_reg_we", last_we, row_access[r] == ACCESS_WRITE);
				check_value("o_reg_addr", last_addr, row_addr[r]);
			end
			if (row_access[r] == ACCESS_WRITE) begin
				check_value("o_reg_wdata", last_data, row_data[r]);
				check_value("register model word", reg_model[row_addr[r]], row_data[r]);
			end
		end
		repeat (4) @(negedge uart_clock);
		check_value("extra o_uart_tx characters", tx_chars.size(), 0);
		check_value("bound assertion failures", dut_i.checker_i.fail_count, 0);
		if (error_count == 0) begin
			$display(">>> PASS");
			$finish;
		end else begin
			report_failure("Errors were counted during the run");
		end
	end

endmodule

// ==== sources.f ====
hdl/monitor_pkg.sv
hdl/frame_counter.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/line_buffer.sv
hdl/reply_buffer.sv
hdl/monitor_fsm.sv
hdl/debug_monitor_top.sv
sim/debug_monitor_checker.sv
sim/tb_debug_monitor.sv

// ==== Bender.yml ====
package:
  name: debug_monitor

sources:
  - hdl/monitor_pkg.sv
  - hdl/frame_counter.sv
  - hdl/uart_rx.sv
  - hdl/uart_tx.sv
  - hdl/line_buffer.sv
  - hdl/reply_buffer.sv
  - hdl/monitor_fsm.sv
  - hdl/debug_monitor_top.sv
  - target: simulation
    files:
      - sim/debug_monitor_checker.sv
      - sim/tb_debug_monitor.sv
